//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_rv_alu_pipe
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_alu_pipe.sv
verification/rv_alu_checker.sv
verification/tb_rv_alu_pipe.sv

//--- rtl/rv_alu_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu_pipe
  import rv_pipe_pkg::*, rv_isa_pkg::*;
(
  input  wire      clk_i,
  input  wire      reset_i,
  input  wire      instr_valid_i,
  output logic     instr_ready_o,
  input  instr_u   instr_i,
  output logic     res_valid_o,
  input  wire      res_ready_i,
  output result_t  res_o
);

  // Decode to execute
  logic      dec_valid;
  logic      dec_ready;
  decoded_t  dec;

  // Execute to writeback
  logic      exe_valid;
  logic      exe_ready;
  result_t   exe;

  // Operand read path
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xword_t    rs1_data;
  xword_t    rs2_data;

  rv_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .dec_valid_o   (dec_valid),
    .dec_ready_i   (dec_ready),
    .dec_o         (dec)
  );

  rv_execute u_execute (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec_valid_i (dec_valid),
    .dec_ready_o (dec_ready),
    .dec_i       (dec),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .exe_valid_o (exe_valid),
    .exe_ready_i (exe_ready),
    .exe_o       (exe)
  );

  rv_writeback u_writeback (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .exe_valid_i (exe_valid),
    .exe_ready_o (exe_ready),
    .exe_i       (exe),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode
  import rv_pipe_pkg::*, rv_isa_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  wire       instr_valid_i,
  output logic      instr_ready_o,
  input  instr_u    instr_i,
  output logic      dec_valid_o,
  input  wire       dec_ready_i,
  output decoded_t  dec_o
);

  decoded_t dec_next;
  logic     is_illegal;
  logic     is_shift;

  ////////////////////
  // Field decode
  assign is_shift = (instr_i.r.funct3 == F3_SLL) || (instr_i.r.funct3 == F3_SR);

  always_comb begin
    dec_next     = '0;
    is_illegal   = 1'b0;
    dec_next.rd  = instr_i.r.rd;
    dec_next.rs1 = instr_i.r.rs1;
    dec_next.rs2 = instr_i.r.rs2;

    // Base operation from funct3
    case (instr_i.r.funct3)
      F3_ADD_SUB: dec_next.alu_op = ALU_ADD;
      F3_SLL:     dec_next.alu_op = ALU_SLL;
      F3_SLT:     dec_next.alu_op = ALU_SLT;
      F3_SLTU:    dec_next.alu_op = ALU_SLTU;
      F3_XOR:     dec_next.alu_op = ALU_XOR;
      F3_SR:      dec_next.alu_op = ALU_SRL;
      F3_OR:      dec_next.alu_op = ALU_OR;
      default:    dec_next.alu_op = ALU_AND;
    endcase

    case (instr_i.r.opcode)
      OPC_OP: begin
        if (instr_i.r.funct7 == F7_ALT) begin
          if (instr_i.r.funct3 == F3_ADD_SUB) begin
            dec_next.alu_op = ALU_SUB;
          end else if (instr_i.r.funct3 == F3_SR) begin
            dec_next.alu_op = ALU_SRA;
          end else begin
            is_illegal = 1'b1;
          end
        end else if (instr_i.r.funct7 != F7_BASE) begin
          is_illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec_next.use_imm = 1'b1;
        dec_next.rs2     = '0;
        dec_next.imm     = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
        if (is_shift) begin
          // Upper immediate bits act as funct7
          dec_next.imm = {{(XLEN-SHAMT_BITS){1'b0}}, instr_i.i.imm12[SHAMT_BITS-1:0]};
          if (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == F3_SR) begin
            dec_next.alu_op = ALU_SRA;
          end else if (instr_i.r.funct7 != F7_BASE) begin
            is_illegal = 1'b1;
          end
        end
      end
      OPC_LUI: begin
        dec_next.alu_op  = ALU_PASS_B;
        dec_next.use_imm = 1'b1;
        dec_next.rs1     = '0;
        dec_next.rs2     = '0;
        dec_next.imm     = {instr_i.u.imm20, {(XLEN-20){1'b0}}};
      end
      default: is_illegal = 1'b1;
    endcase

    // Illegal words carry nothing but the flag
    if (is_illegal) begin
      dec_next         = '0;
      dec_next.illegal = 1'b1;
    end
  end

  ////////////////////
  // Output register
  assign instr_ready_o = ~dec_valid_o | dec_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
      dec_o       <= '0;
    end else if (instr_valid_i && instr_ready_o) begin
      dec_valid_o <= 1'b1;
      dec_o       <= dec_next;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  // Writeback relies on rd zero to skip the register write
  a_illegal_no_rd : assert property (@(posedge clk_i) disable iff (reset_i)
    (dec_valid_o && dec_o.illegal) |-> (dec_o.rd == '0))
    else $error("illegal decode carries non-zero rd");

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute
  import rv_pipe_pkg::*;
(
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        dec_valid_i,
  output logic       dec_ready_o,
  input  decoded_t   dec_i,
  output reg_addr_t  rs1_addr_o,
  output reg_addr_t  rs2_addr_o,
  input  xword_t     rs1_data_i,
  input  xword_t     rs2_data_i,
  output logic       exe_valid_o,
  input  wire        exe_ready_i,
  output result_t    exe_o
);

  logic                  fwd_rs1;
  logic                  fwd_rs2;
  logic                  exe_can_fwd;
  xword_t                op_a;
  xword_t                rs2_val;
  xword_t                op_b;
  xword_t                alu_res;
  logic [SHAMT_BITS-1:0] shamt;

  ////////////////////
  // Operand fetch and forwarding
  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  // Only the held result is missing from the register file
  assign exe_can_fwd = exe_valid_o && !exe_o.illegal && (exe_o.rd != '0);
  assign fwd_rs1     = exe_can_fwd && (exe_o.rd == dec_i.rs1);
  assign fwd_rs2     = exe_can_fwd && (exe_o.rd == dec_i.rs2);

  assign op_a    = fwd_rs1 ? exe_o.value : rs1_data_i;
  assign rs2_val = fwd_rs2 ? exe_o.value : rs2_data_i;
  assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;
  assign shamt   = op_b[SHAMT_BITS-1:0];

  ////////////////////
  // ALU
  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  ////////////////////
  // Output register
  assign dec_ready_o = ~exe_valid_o | exe_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_valid_o <= 1'b0;
      exe_o       <= '0;
    end else if (dec_valid_i && dec_ready_o) begin
      exe_valid_o   <= 1'b1;
      exe_o.rd      <= dec_i.rd;
      exe_o.value   <= alu_res;
      exe_o.illegal <= dec_i.illegal;
    end else if (exe_ready_i) begin
      exe_valid_o <= 1'b0;
    end
  end

  // A stalled result must not change, forwarding reads it too
  a_exe_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    (exe_valid_o && !exe_ready_i) |=> (exe_valid_o && $stable(exe_o)))
    else $error("execute output changed while stalled");

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  ////////////////////
  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  ////////////////////
  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // ALT picks SUB, SRA and SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  ////////////////////
  // Instruction formats
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // One instruction word, seen through each format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } instr_u;

endpackage

`default_nettype wire

//--- rtl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  localparam int XLEN       = 32;
  localparam int REG_BITS   = 5;
  localparam int SHAMT_BITS = $clog2(XLEN);

  typedef logic [XLEN-1:0]     xword_t;
  typedef logic [REG_BITS-1:0] reg_addr_t;

  // ALU_ADD must stay zero, an illegal item decodes to all zeros
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  ////////////////////
  // Decode to execute
  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_imm;
    xword_t    imm;
    logic      illegal;
  } decoded_t;

  ////////////////////
  // Execute to writeback and out
  typedef struct packed {
    reg_addr_t rd;
    xword_t    value;
    logic      illegal;
  } result_t;

endpackage

`default_nettype wire

//--- rtl/rv_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module rv_writeback
  import rv_pipe_pkg::*;
(
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        exe_valid_i,
  output logic       exe_ready_o,
  input  result_t    exe_i,
  input  reg_addr_t  rs1_addr_i,
  input  reg_addr_t  rs2_addr_i,
  output xword_t     rs1_data_o,
  output xword_t     rs2_data_o,
  output logic       res_valid_o,
  input  wire        res_ready_i,
  output result_t    res_o
);

  xword_t regs [2**REG_BITS];
  logic   accept;
  logic   rf_write;

  assign exe_ready_o = ~res_valid_o | res_ready_i;
  assign accept      = exe_valid_i && exe_ready_o;
  assign rf_write    = accept && (exe_i.rd != '0) && !exe_i.illegal;

  ////////////////////
  // Register file, asynchronous read
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**REG_BITS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_write) begin
      regs[exe_i.rd] <= exe_i.value;
    end
  end

  ////////////////////
  // Result register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
      res_o       <= '0;
    end else if (accept) begin
      res_valid_o <= 1'b1;
      res_o       <= exe_i;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  // x0 is never written, so reads of it stay zero
  a_x0_zero : assert property (@(posedge clk_i) disable iff (reset_i)
    (rs1_addr_i != '0 || rs1_data_o == '0) && (rs2_addr_i != '0 || rs2_data_o == '0))
    else $error("register x0 read non-zero");

endmodule

`default_nettype wire

//--- verification/rv_alu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu_checker
  import rv_pipe_pkg::*, rv_isa_pkg::*;
(
  input  wire      clk_i,
  input  wire      reset_i,
  input  wire      instr_valid_i,
  input  wire      instr_ready_i,
  input  instr_u   instr_i,
  input  wire      res_valid_i,
  input  wire      res_ready_i,
  input  result_t  res_i,
  output int       checked_o,
  output int       mismatch_o,
  output int       orphan_o,
  output int       pending_o
);

  logic [31:0] in_flight [$];
  xword_t      model [32];

  ////////////////////
  // Reference model decoding straight from the bit fields
  function automatic result_t ref_result(input logic [31:0] w);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] sh;
    xword_t     a;
    xword_t     b;
    logic       alt;
    logic       f7_ok;
    result_t    r;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model[w[19:15]];
    b     = (opc == OPC_OP) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh    = b[4:0];
    alt   = (f7 == F7_ALT);
    f7_ok = (f7 == F7_BASE) || (alt && (f3 == F3_SR || (f3 == F3_ADD_SUB && opc == OPC_OP)));
    // Non-shift immediates have no funct7 field
    if (opc == OPC_OP_IMM && f3 != F3_SLL && f3 != F3_SR) begin
      f7_ok = 1'b1;
      alt   = 1'b0;
    end
    r.rd      = w[11:7];
    r.illegal = 1'b0;
    r.value   = '0;
    if (opc == OPC_LUI) begin
      r.value = {w[31:12], 12'b0};
    end else if ((opc == OPC_OP || opc == OPC_OP_IMM) && f7_ok) begin
      case (f3)
        F3_ADD_SUB: r.value = alt ? a - b : a + b;
        F3_SLL:     r.value = a << sh;
        F3_SLT:     r.value = {31'b0, $signed(a) < $signed(b)};
        F3_SLTU:    r.value = {31'b0, a < b};
        F3_XOR:     r.value = a ^ b;
        F3_OR:      r.value = a | b;
        F3_AND:     r.value = a & b;
        default: begin
          if (alt) begin
            r.value = $signed(a) >>> sh;
          end else begin
            r.value = a >> sh;
          end
        end
      endcase
    end else begin
      r.rd      = '0;
      r.illegal = 1'b1;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] want, input logic [31:0] got);
    if (got !== want) begin
      $display("FAILED %s: expected %h, got %h", name, want, got);
      mismatch_o++;
    end
  endtask

  ////////////////////
  // Compare on each output transfer
  always @(posedge clk_i) begin
    result_t want;
    if (reset_i) begin
      in_flight.delete();
      for (int k = 0; k < 32; k++) begin
        model[k] = '0;
      end
    end else begin
      if (instr_valid_i && instr_ready_i) begin
        in_flight.push_back(instr_i);
      end
      if (res_valid_i && res_ready_i) begin
        if (in_flight.size() == 0) begin
          $display("Result came out with no instruction in flight");
          orphan_o++;
        end else begin
          want = ref_result(in_flight.pop_front());
          // Same write rule as the pipeline
          if (!want.illegal && want.rd != '0) begin
            model[want.rd] = want.value;
          end
          checked_o++;
          check_field("res_o.rd", {27'b0, want.rd}, {27'b0, res_i.rd});
          check_field("res_o.value", want.value, res_i.value);
          check_field("res_o.illegal", {31'b0, want.illegal}, {31'b0, res_i.illegal});
        end
      end
    end
    pending_o = in_flight.size();
  end

endmodule

`default_nettype wire

//--- verification/tb_rv_alu_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_alu_pipe
  import rv_pipe_pkg::*, rv_isa_pkg::*;
();

  localparam int NUM_RANDOM = 400;
  localparam int WAIT_LIMIT = 100;

  logic        clk_i;
  logic        reset_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  instr_u      instr_i;
  logic        res_valid_o;
  logic        res_ready_i;
  result_t     res_o;

  logic [15:0] lfsr;
  logic        bp_on;
  int          sent;
  int          tb_errors;
  int          timeouts;
  int          checked;
  int          mismatches;
  int          orphans;
  int          pending;

  rv_alu_pipe i_rv_alu_pipe (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_o         (res_o)
  );

  rv_alu_checker i_rv_alu_checker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_i (instr_ready_o),
    .instr_i       (instr_i),
    .res_valid_i   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_i         (res_o),
    .checked_o     (checked),
    .mismatch_o    (mismatches),
    .orphan_o      (orphans),
    .pending_o     (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Random source
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Mostly x0..x3 so neighbours depend on each other
  task automatic rand_reg(output logic [4:0] r);
    logic [31:0] v;
    take_bits(3, v);
    if (v[2:0] == 3'd7) begin
      take_bits(5, v);
    end else begin
      v = {30'b0, v[1:0]};
    end
    r = v[4:0];
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  task automatic rand_instr(output logic [31:0] w);
    logic [31:0] kind;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    take_bits(4, kind);
    take_bits(3, f3);
    take_bits(1, alt);
    take_bits(20, imm);
    rand_reg(rd);
    rand_reg(rs1);
    rand_reg(rs2);
    // Alternate funct7 only where it has a meaning
    if (f3[2:0] != F3_ADD_SUB && f3[2:0] != F3_SR) begin
      alt = '0;
    end
    if (kind < 7) begin
      w = enc_r(alt[0] ? F7_ALT : F7_BASE, rs2, rs1, f3[2:0], rd);
    end else if (kind < 13) begin
      if (f3[2:0] == F3_SLL || f3[2:0] == F3_SR) begin
        imm[11:5] = alt[0] ? F7_ALT : F7_BASE;
      end
      w = enc_i(imm[11:0], rs1, f3[2:0], rd);
    end else if (kind < 15) begin
      w = {imm[19:0], rd, OPC_LUI};
    end else begin
      // Load opcode, not in the kept set
      w = {imm[11:0], rs1, f3[2:0], rd, 7'b0000011};
    end
  endtask

  ////////////////////
  // Driving and waiting
  task automatic drive_ready();
    logic [31:0] v;
    if (bp_on) begin
      take_bits(2, v);
      res_ready_i = (v[1:0] != 2'b00);
    end else begin
      res_ready_i = 1'b1;
    end
  endtask

  task automatic send_instr(input logic [31:0] w);
    int   waited;
    logic done;
    instr_valid_i = 1'b1;
    instr_i       = w;
    waited        = 0;
    done          = 1'b0;
    while (!done && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      done = instr_ready_o;
      waited++;
      @(negedge clk_i);
      drive_ready();
    end
    instr_valid_i = 1'b0;
    if (done) begin
      sent++;
    end else begin
      $display("Timeout: instruction %h was never accepted", w);
      timeouts++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d results never came out", pending);
      timeouts++;
    end
  endtask

  task automatic expect_bit(input string name, input logic want, input logic got);
    if (got !== want) begin
      $display("FAILED %s: expected %h, got %h", name, want, got);
      tb_errors++;
    end
  endtask

  // Quiet output after reset, then three edges from accept to result
  task automatic check_first_latency();
    repeat (3) begin
      @(negedge clk_i);
      expect_bit("res_valid_o", 1'b0, res_valid_o);
      expect_bit("instr_ready_o", 1'b1, instr_ready_o);
    end
    instr_valid_i = 1'b1;
    instr_i       = enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd1);
    @(posedge clk_i);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    sent++;
    expect_bit("res_valid_o", 1'b0, res_valid_o);
    @(negedge clk_i);
    expect_bit("res_valid_o", 1'b0, res_valid_o);
    @(negedge clk_i);
    expect_bit("res_valid_o", 1'b1, res_valid_o);
  endtask

  task automatic run_directed();
    // x1 = 0x80000000, x2 = -5, x4 = 3
    send_instr({20'h80000, 5'd1, OPC_LUI});
    send_instr(enc_i(12'hFFB, 5'd0, F3_ADD_SUB, 5'd2));
    send_instr(enc_i({F7_ALT, 5'd4}, 5'd1, F3_SR, 5'd3));
    send_instr(enc_i({F7_BASE, 5'd4}, 5'd1, F3_SR, 5'd3));
    send_instr(enc_i(12'd3, 5'd0, F3_ADD_SUB, 5'd4));
    send_instr(enc_r(F7_ALT, 5'd4, 5'd2, F3_SR, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd4, 5'd2, F3_SR, 5'd3));
    // Signed and unsigned compares disagree on -5 against 3
    send_instr(enc_r(F7_BASE, 5'd4, 5'd2, F3_SLT, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd4, 5'd2, F3_SLTU, 5'd3));
    send_instr(enc_r(F7_ALT, 5'd2, 5'd4, F3_ADD_SUB, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd3, 5'd3, F3_ADD_SUB, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd4, 5'd1, F3_SLL, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd2, 5'd4, F3_OR, 5'd3));
    send_instr(enc_r(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd3));
    send_instr(enc_i(12'h7F0, 5'd2, F3_SLTU, 5'd3));
    // Write to x0, then read it back
    send_instr(enc_i(12'd7, 5'd0, F3_ADD_SUB, 5'd0));
    send_instr(enc_r(F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd3));
    send_instr(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
    send_instr(enc_i({F7_ALT, 5'd1}, 5'd1, F3_SLL, 5'd3));
    send_instr(32'hFFFFFFFF);
  endtask

  ////////////////////
  // Main sequence
  initial begin
    logic [31:0] w;
    lfsr          = 16'd58957;
    bp_on         = 1'b0;
    sent          = 0;
    tb_errors     = 0;
    timeouts      = 0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_ready_i   = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_first_latency();
    run_directed();
    bp_on = 1'b1;
    for (int n = 0; n < NUM_RANDOM && timeouts == 0; n++) begin
      rand_instr(w);
      send_instr(w);
    end
    bp_on       = 1'b0;
    res_ready_i = 1'b1;
    if (timeouts == 0) begin
      wait_drain();
    end
    if (timeouts == 0 && checked != sent) begin
      $display("Got %0d results for %0d accepted instructions", checked, sent);
      tb_errors++;
    end
    $display("%0d results checked, %0d mismatches, %0d unexpected, %0d other errors, %0d timeouts",
             checked, mismatches, orphans, tb_errors, timeouts);
    if (mismatches + orphans + tb_errors + timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
